/* design/background_drawer.sv */
`timescale 1ns/1ps

module background_drawer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start,
    output logic                  done,
    output logic                  wr_en,
    output render_pkg::fb_write_t wr
);

    render_pkg::addr_t addr;
    logic              finished;
    logic              at_end;

    assign at_end  = addr == render_pkg::last_addr;
    assign wr_en   = start && !finished;
    assign done    = wr_en && at_end;
    assign wr.addr = addr;
    assign wr.data = render_pkg::bg_color;

    // One address per cycle, rearmed once start drops
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr     <= '0;
            finished <= 1'b0;
        end else if (!start) begin
            addr     <= '0;
            finished <= 1'b0;
        end else if (wr_en) begin
            if (at_end) begin
                addr     <= '0;
                finished <= 1'b1;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    a_addr_range: assert property (
        @(posedge clk) disable iff (!rstn)
        wr_en |-> addr <= render_pkg::last_addr
    ) else $error("background_drawer: address past end of buffer");

endmodule

/* design/depth_buffer.sv */
`timescale 1ns/1ps

module depth_buffer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  pix_valid,
    input  render_pkg::pixel_t    pix,
    input  logic                  shade_mode,
    input  logic                  clear_en,
    input  render_pkg::addr_t     clear_addr,
    output logic                  wr_en,
    output render_pkg::fb_write_t wr,
    output logic                  last_done
);

    logic [render_pkg::depth_w-1:0] mem [render_pkg::buf_size];

    render_pkg::addr_t              in_addr;
    render_pkg::addr_t              s1_addr;
    logic                           s1_valid;
    render_pkg::pixel_t             s1_pix;
    logic [render_pkg::depth_w-1:0] s1_depth;
    logic                           s1_win;

    assign in_addr = render_pkg::to_addr(pix.coord);

    // Strictly nearer wins, so equal depth keeps the earlier pixel
    assign s1_win = s1_valid && s1_pix.covered && (s1_pix.depth < s1_depth);

    // Stage one, stored depth read
    always_ff @(posedge clk) begin
        s1_pix  <= pix;
        s1_addr <= in_addr;
        // Same address being written right now
        if (s1_win && s1_addr == in_addr) begin
            s1_depth <= s1_pix.depth;
        end else begin
            s1_depth <= mem[in_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (clear_en) begin
            mem[clear_addr] <= render_pkg::depth_far;
        end else if (s1_win) begin
            mem[s1_addr] <= s1_pix.depth;
        end
    end

    // Stage two, framebuffer write or drop
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid  <= 1'b0;
            wr_en     <= 1'b0;
            last_done <= 1'b0;
        end else begin
            s1_valid  <= pix_valid;
            wr_en     <= s1_win;
            last_done <= s1_valid && s1_pix.last;
        end
    end

    always_ff @(posedge clk) begin
        wr.addr <= s1_addr;
        // Grey level from the top nibble of depth
        wr.data <= shade_mode ? {3{s1_pix.depth[render_pkg::depth_w-1 -: 4]}} : s1_pix.color;
    end

    // Clearing and drawing belong to different frame phases
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rstn)
        !(clear_en && pix_valid)
    ) else $error("depth_buffer: clear while pixels arrive");

endmodule

/* design/drawing_manager.sv */
`timescale 1ns/1ps

module drawing_manager (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  draw_start,
    input  logic                  draw_ack,
    input  logic                  shade_mode,
    input  logic                  tri_valid,
    output logic                  tri_ready,
    input  render_pkg::tri_in_t   tri_data,
    output logic                  fb_en,
    output render_pkg::fb_write_t fb_write,
    output logic                  frame_done
);

    typedef enum logic [2:0] {
        IDLE,
        BACKGROUND,
        GRAPHICS,
        MARKER,
        FRAME_DONE
    } state_t;

    state_t state, next_state;
    logic   shade_r;
    logic   marker_phase;
    logic   gfx;

    logic                  slice_ready;
    logic                  slice_valid;
    render_pkg::tri_in_t   slice_tri;
    logic                  rast_ready;
    logic                  rast_valid;
    render_pkg::pixel_t    rast_pix;
    logic                  pix_valid;
    render_pkg::pixel_t    pix;

    logic                  bg_start, bg_done, bg_en;
    render_pkg::fb_write_t bg_wr;
    logic                  depth_en, last_done;
    render_pkg::fb_write_t depth_wr;

    ////////////////////////////////////////////////////////////
    // Triangle path
    ////////////////////////////////////////////////////////////

    // Triangles only enter during GRAPHICS
    assign gfx       = state == GRAPHICS;
    assign tri_ready = gfx && slice_ready;

    pipe_stage #(.payload_t(render_pkg::tri_in_t)) u_tri_stage (
        .clk     (clk),
        .rstn    (rstn),
        .s_valid (tri_valid && gfx),
        .s_ready (slice_ready),
        .s_data  (tri_data),
        .m_valid (slice_valid),
        .m_ready (rast_ready),
        .m_data  (slice_tri)
    );

    rasterizer u_rasterizer (
        .clk       (clk),
        .rstn      (rstn),
        .tri_valid (slice_valid),
        .tri_ready (rast_ready),
        .tri_data  (slice_tri),
        .pix_valid (rast_valid),
        .pix       (rast_pix)
    );

    // Depth buffer never stalls
    pipe_stage #(.payload_t(render_pkg::pixel_t)) u_pix_stage (
        .clk     (clk),
        .rstn    (rstn),
        .s_valid (rast_valid),
        .s_ready (),
        .s_data  (rast_pix),
        .m_valid (pix_valid),
        .m_ready (1'b1),
        .m_data  (pix)
    );

    depth_buffer u_depth_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .shade_mode (shade_r),
        .clear_en   (bg_en),
        .clear_addr (bg_wr.addr),
        .wr_en      (depth_en),
        .wr         (depth_wr),
        .last_done  (last_done)
    );

    ////////////////////////////////////////////////////////////
    // Background clear
    ////////////////////////////////////////////////////////////

    assign bg_start = state == BACKGROUND;

    background_drawer u_background_drawer (
        .clk   (clk),
        .rstn  (rstn),
        .start (bg_start),
        .done  (bg_done),
        .wr_en (bg_en),
        .wr    (bg_wr)
    );

    ////////////////////////////////////////////////////////////
    // Frame FSM and write mux
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state        <= IDLE;
            shade_r      <= 1'b0;
            marker_phase <= 1'b0;
        end else begin
            state <= next_state;
            // Shade mode fixed for the whole frame
            if (next_state == BACKGROUND && state != BACKGROUND) begin
                shade_r <= shade_mode;
            end
            if (state == MARKER) begin
                marker_phase <= !marker_phase;
            end
        end
    end

    always_comb begin
        next_state = state;
        fb_en      = 1'b0;
        fb_write   = '0;
        frame_done = 1'b0;
        case (state)
            IDLE: begin
                if (draw_start) begin
                    next_state = BACKGROUND;
                end
            end
            BACKGROUND: begin
                fb_en    = bg_en;
                fb_write = bg_wr;
                if (bg_done) begin
                    next_state = GRAPHICS;
                end
            end
            GRAPHICS: begin
                fb_en    = depth_en;
                fb_write = depth_wr;
                if (last_done) begin
                    next_state = MARKER;
                end
            end
            MARKER: begin
                // Toggles every frame so the frame rate shows on screen
                fb_en         = 1'b1;
                fb_write.addr = render_pkg::last_addr;
                fb_write.data = marker_phase ? render_pkg::marker_off_color
                                             : render_pkg::marker_on_color;
                next_state    = FRAME_DONE;
            end
            FRAME_DONE: begin
                frame_done = 1'b1;
                if (draw_ack) begin
                    next_state = BACKGROUND;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* design/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     s_valid,
    output logic     s_ready,
    input  payload_t s_data,
    output logic     m_valid,
    input  logic     m_ready,
    output payload_t m_data
);

    // Take a new word when empty or when the current one leaves
    assign s_ready = !m_valid || m_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_valid <= 1'b0;
        end else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            m_data <= s_data;
        end
    end

    // Downstream may rely on a stalled word not moving
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        m_valid && !m_ready |=> $stable(m_data)
    ) else $error("pipe_stage: payload changed while stalled");

endmodule

/* design/rasterizer.sv */
`timescale 1ns/1ps

module rasterizer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tri_valid,
    output logic                tri_ready,
    input  render_pkg::tri_in_t tri_data,
    output logic                pix_valid,
    output render_pkg::pixel_t  pix
);

    typedef logic signed [render_pkg::edge_w-1:0] edge_t;

    // Positive on the left of a->b
    function automatic edge_t edge_at(render_pkg::coord_t a, render_pkg::coord_t b,
                                      logic [4:0] px, logic [3:0] py);
        edge_t dx;
        edge_t dy;
        dx = edge_t'(b.x) - edge_t'(a.x);
        dy = edge_t'(b.y) - edge_t'(a.y);
        return dx * (edge_t'(py) - edge_t'(a.y)) - dy * (edge_t'(px) - edge_t'(a.x));
    endfunction

    function automatic logic [4:0] min3(logic [4:0] a, logic [4:0] b, logic [4:0] c);
        logic [4:0] m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic logic [4:0] max3(logic [4:0] a, logic [4:0] b, logic [4:0] c);
        logic [4:0] m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    function automatic logic [4:0] clamp(logic [4:0] v, logic [4:0] lim);
        return (v > lim) ? lim : v;
    endfunction

    render_pkg::coord_t v [3];
    logic [4:0] lo_x, hi_x;
    logic [3:0] lo_y, hi_y;
    edge_t      e_start [3];

    logic       busy;
    logic [4:0] x, min_x, max_x;
    logic [3:0] y, max_y;
    edge_t      e_cur [3];
    edge_t      e_row [3];
    edge_t      step_x [3];
    edge_t      step_y [3];
    logic [render_pkg::depth_w-1:0] depth;
    logic [render_pkg::color_w-1:0] color;
    logic       last_tri;
    logic       row_end, box_end;

    ////////////////////////////////////////////////////////////
    // Bounding box and edge values at its top-left corner
    ////////////////////////////////////////////////////////////

    always_comb begin
        v[0] = tri_data.triangle.v0;
        v[1] = tri_data.triangle.v1;
        v[2] = tri_data.triangle.v2;
        lo_x = clamp(min3(v[0].x, v[1].x, v[2].x), 5'(render_pkg::buf_width - 1));
        hi_x = clamp(max3(v[0].x, v[1].x, v[2].x), 5'(render_pkg::buf_width - 1));
        lo_y = 4'(clamp(min3(5'(v[0].y), 5'(v[1].y), 5'(v[2].y)),
                        5'(render_pkg::buf_height - 1)));
        hi_y = 4'(clamp(max3(5'(v[0].y), 5'(v[1].y), 5'(v[2].y)),
                        5'(render_pkg::buf_height - 1)));
        for (int i = 0; i < 3; i++) begin
            e_start[i] = edge_at(v[i], v[(i + 1) % 3], lo_x, lo_y);
        end
    end

    ////////////////////////////////////////////////////////////
    // Scan
    ////////////////////////////////////////////////////////////

    assign tri_ready = !busy;
    assign row_end   = x == max_x;
    assign box_end   = row_end && y == max_y;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
        end else if (tri_valid && tri_ready) begin
            busy <= 1'b1;
        end else if (busy && box_end) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tri_valid && tri_ready) begin
            min_x    <= lo_x;
            max_x    <= hi_x;
            max_y    <= hi_y;
            x        <= lo_x;
            y        <= lo_y;
            depth    <= tri_data.triangle.depth;
            color    <= tri_data.triangle.color;
            last_tri <= tri_data.last;
            for (int i = 0; i < 3; i++) begin
                e_cur[i]  <= e_start[i];
                e_row[i]  <= e_start[i];
                step_x[i] <= edge_t'(v[i].y) - edge_t'(v[(i + 1) % 3].y);
                step_y[i] <= edge_t'(v[(i + 1) % 3].x) - edge_t'(v[i].x);
            end
        end else if (busy) begin
            if (row_end) begin
                // Back to the left edge, one row down
                x <= min_x;
                y <= y + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e_row[i] <= e_row[i] + step_y[i];
                    e_cur[i] <= e_row[i] + step_y[i];
                end
            end else begin
                x <= x + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e_cur[i] <= e_cur[i] + step_x[i];
                end
            end
        end
    end

    assign pix_valid = busy;

    always_comb begin
        pix.coord.x = x;
        pix.coord.y = y;
        pix.depth   = depth;
        pix.color   = color;
        // Inside or on every edge
        pix.covered = !e_cur[0][render_pkg::edge_w-1] &&
                      !e_cur[1][render_pkg::edge_w-1] &&
                      !e_cur[2][render_pkg::edge_w-1];
        pix.last    = last_tri && box_end;
    end

endmodule

/* design/render_pkg.sv */
package render_pkg;

    ////////////////////////////////////////////////////////////
    // Framebuffer geometry
    ////////////////////////////////////////////////////////////

    localparam int buf_width  = 16;
    localparam int buf_height = 12;
    localparam int buf_size   = buf_width * buf_height;
    localparam int buf_addr_w = $clog2(buf_size);

    localparam int color_w = 12;
    localparam int depth_w = 8;

    // Edge function range, enough for any 5x4 bit coordinate pair
    localparam int edge_w = 12;

    // Bottom-right pixel, also where the frame marker goes
    localparam logic [buf_addr_w-1:0] last_addr = buf_addr_w'(buf_size - 1);

    // Far plane
    localparam logic [depth_w-1:0] depth_far = '1;

    localparam logic [color_w-1:0] bg_color         = 12'h222;
    localparam logic [color_w-1:0] marker_on_color  = 12'hf00;
    localparam logic [color_w-1:0] marker_off_color = 12'h00f;

    ////////////////////////////////////////////////////////////
    // Stream payloads
    ////////////////////////////////////////////////////////////

    typedef logic [buf_addr_w-1:0] addr_t;

    typedef struct packed {
        logic [4:0] x;
        logic [3:0] y;
    } coord_t;

    // Vertices are expected counter-clockwise
    typedef struct packed {
        coord_t               v0;
        coord_t               v1;
        coord_t               v2;
        logic [depth_w-1:0]   depth;
        logic [color_w-1:0]   color;
    } triangle_t;

    typedef struct packed {
        triangle_t triangle;
        logic      last;
    } tri_in_t;

    typedef struct packed {
        coord_t               coord;
        logic [depth_w-1:0]   depth;
        logic [color_w-1:0]   color;
        logic                 covered;
        logic                 last;
    } pixel_t;

    typedef struct packed {
        addr_t                addr;
        logic [color_w-1:0]   data;
    } fb_write_t;

    // Row-major framebuffer address
    function automatic addr_t to_addr(coord_t c);
        return addr_t'(c.y) * addr_t'(buf_width) + addr_t'(c.x);
    endfunction

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module drawing_manager_tb -f vlog.f -o sim_drawing_manager

./obj_dir/sim_drawing_manager | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* testbench/drawing_manager_tb.sv */
`timescale 1ns/1ps

module drawing_manager_tb;

    logic                  clk;
    logic                  rstn;
    logic                  draw_start;
    logic                  draw_ack;
    logic                  shade_mode;
    logic                  tri_valid;
    logic                  tri_ready;
    render_pkg::tri_in_t   tri_data;
    logic                  fb_en;
    render_pkg::fb_write_t fb_write;
    logic                  frame_done;

    // Image written by the DUT and the one expected from the triangle list
    logic [render_pkg::color_w-1:0] fb_img    [render_pkg::buf_size];
    logic [render_pkg::color_w-1:0] ref_img   [render_pkg::buf_size];
    int                             ref_depth [render_pkg::buf_size];

    render_pkg::tri_in_t tris     [$];
    int                  pix_addr [$];
    int                  pix_data [$];

    logic [31:0] lfsr;
    int          wr_count;
    int          frame_no;
    bit          marker_red;
    bit          timed_out;
    int          checks;
    int          errors;
    int          tests;
    int          failed_tests;

    tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    drawing_manager uut (
        .clk        (clk),
        .rstn       (rstn),
        .draw_start (draw_start),
        .draw_ack   (draw_ack),
        .shade_mode (shade_mode),
        .tri_valid  (tri_valid),
        .tri_ready  (tri_ready),
        .tri_data   (tri_data),
        .fb_en      (fb_en),
        .fb_write   (fb_write),
        .frame_done (frame_done)
    );

    ////////////////////////////////////////////////////////////
    // Checking and random helpers
    ////////////////////////////////////////////////////////////

    task automatic compare(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int first_error);
        tests++;
        if (errors == first_error) begin
            $display("test %s: pass", name);
        end else begin
            failed_tests++;
            $display("test %s: FAIL with %0d errors", name, errors - first_error);
        end
    endtask

    task automatic note_timeout(input string why);
        errors++;
        timed_out = 1'b1;
        $display("Timeout at %0d ns: %s", $time, why);
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference image from the triangle rules
    ////////////////////////////////////////////////////////////

    // All three edge functions zero or greater at the pixel
    function automatic bit covered(input render_pkg::triangle_t t, input int px, input int py);
        int vx [3];
        int vy [3];
        int j;
        int e;
        vx[0] = t.v0.x;
        vy[0] = t.v0.y;
        vx[1] = t.v1.x;
        vy[1] = t.v1.y;
        vx[2] = t.v2.x;
        vy[2] = t.v2.y;
        for (int i = 0; i < 3; i++) begin
            j = (i + 1) % 3;
            e = (vx[j] - vx[i]) * (py - vy[i]) - (vy[j] - vy[i]) * (px - vx[i]);
            if (e < 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic build_reference(input bit shade);
        render_pkg::triangle_t t;
        int a;
        for (a = 0; a < render_pkg::buf_size; a++) begin
            ref_img[a]   = render_pkg::bg_color;
            ref_depth[a] = render_pkg::depth_far;
        end
        foreach (tris[i]) begin
            t = tris[i].triangle;
            for (int py = 0; py < render_pkg::buf_height; py++) begin
                for (int px = 0; px < render_pkg::buf_width; px++) begin
                    a = py * render_pkg::buf_width + px;
                    if (covered(t, px, py) && t.depth < ref_depth[a]) begin
                        ref_depth[a] = t.depth;
                        ref_img[a]   = shade ? {3{t.depth[7:4]}} : t.color;
                    end
                end
            end
        end
        ref_img[render_pkg::buf_size-1] = marker_red ? render_pkg::marker_on_color
                                                     : render_pkg::marker_off_color;
    endtask

    task automatic check_frame(input int sum);
        int total;
        total = 0;
        for (int a = 0; a < render_pkg::buf_size; a++) begin
            compare($sformatf("pixel %0d", a), fb_img[a], ref_img[a]);
            total += fb_img[a];
        end
        foreach (pix_addr[i]) begin
            compare($sformatf("listed pixel %0d", pix_addr[i]),
                    fb_img[pix_addr[i]], pix_data[i]);
        end
        compare("image checksum", total, sum);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus on the falling edge
    ////////////////////////////////////////////////////////////

    // The first 192 writes of every frame are the clear
    always @(negedge clk) begin
        if (rstn && fb_en) begin
            if (wr_count < render_pkg::buf_size) begin
                compare("clear address", fb_write.addr, wr_count);
                compare("clear colour", fb_write.data, render_pkg::bg_color);
            end
            fb_img[fb_write.addr] = fb_write.data;
            wr_count++;
        end
    end

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (!rstn && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                note_timeout("reset was never released");
            end
        end
    endtask

    task automatic start_frame(input bit shade);
        int hold;
        if (frame_no == 0) begin
            draw_start = 1'b1;
        end else begin
            // frame_done has to stay up however long the ack takes
            hold = random_bits(3);
            repeat (hold) begin
                @(negedge clk);
                compare("frame_done held", frame_done, 1);
            end
            draw_ack = 1'b1;
        end
        shade_mode = shade;
        wr_count   = 0;
        @(negedge clk);
        draw_start = 1'b0;
        draw_ack   = 1'b0;
        // Live input flips while the frame keeps the latched mode
        shade_mode = !shade;
        compare("frame_done after start", frame_done, 0);
    endtask

    task automatic send_triangle(input render_pkg::tri_in_t t);
        int gap;
        int waited;
        gap = random_bits(2);
        repeat (gap) @(negedge clk);
        tri_valid = 1'b1;
        tri_data  = t;
        waited    = 0;
        while (!tri_ready && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > 1000) begin
                note_timeout("triangle was never accepted");
            end
        end
        // Transfer on the rising edge in between
        @(negedge clk);
        tri_valid = 1'b0;
        if (!timed_out) begin
            compare("clear done before triangle", wr_count >= render_pkg::buf_size, 1);
        end
    endtask

    task automatic wait_frame_done();
        int waited;
        waited = 0;
        while (!frame_done && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > 3000) begin
                note_timeout($sformatf("frame %0d never raised frame_done", frame_no));
            end
        end
    endtask

    task automatic run_frame(input bit shade, input int sum);
        int first_error;
        first_error = errors;
        start_frame(shade);
        foreach (tris[i]) begin
            if (!timed_out) send_triangle(tris[i]);
        end
        if (!timed_out) wait_frame_done();
        if (!timed_out) begin
            build_reference(shade);
            check_frame(sum);
            marker_red = !marker_red;
        end
        report_test($sformatf("frame %0d (%0d triangles, shade %0d)",
                              frame_no, tris.size(), shade),
                    first_error);
        frame_no++;
    endtask

    initial begin
        int                  fd;
        int                  n;
        int                  sum;
        int                  f [9];
        bit                  shade;
        string               line;
        render_pkg::tri_in_t t;

        draw_start   = 1'b0;
        draw_ack     = 1'b0;
        shade_mode   = 1'b0;
        tri_valid    = 1'b0;
        tri_data     = '0;
        lfsr         = 32'hc95c_2ca2;
        wr_count     = 0;
        frame_no     = 0;
        marker_red   = 1'b1;
        timed_out    = 1'b0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        shade        = 1'b0;

        @(negedge clk);
        compare("fb_en in reset", fb_en, 0);
        compare("frame_done in reset", frame_done, 0);
        compare("tri_ready in reset", tri_ready, 0);
        wait_reset_release();
        @(negedge clk);
        compare("fb_en after reset", fb_en, 0);
        compare("frame_done after reset", frame_done, 0);
        compare("tri_ready after reset", tri_ready, 0);
        report_test("reset", 0);

        fd = $fopen("testbench/frame_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open testbench/frame_input.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                case (line.getc(0))
                    "F": begin
                        n = $sscanf(line, "F %d", f[0]);
                        compare("frame record fields", n, 1);
                        shade = (f[0] != 0);
                        tris.delete();
                        pix_addr.delete();
                        pix_data.delete();
                    end
                    "T": begin
                        n = $sscanf(line, "T %d %d %d %d %d %d %h %h %d",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                        compare("triangle record fields", n, 9);
                        // Field order of tri_in_t
                        t = {5'(f[0]), 4'(f[1]), 5'(f[2]), 4'(f[3]), 5'(f[4]), 4'(f[5]),
                             8'(f[6]), 12'(f[7]), 1'(f[8])};
                        tris.push_back(t);
                    end
                    "P": begin
                        n = $sscanf(line, "P %d %h", f[0], f[1]);
                        compare("pixel record fields", n, 2);
                        pix_addr.push_back(f[0]);
                        pix_data.push_back(f[1]);
                    end
                    "S": begin
                        n = $sscanf(line, "S %h", sum);
                        compare("checksum record fields", n, 1);
                        run_frame(shade, sum);
                    end
                    default: begin
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/frame_input.txt */
# F shade                                  frame start, shade 1 draws depth as grey
# T x0 y0 x1 y1 x2 y2 depth color last     counter-clockwise, depth and color hex
# P addr data                              expected word after the frame, addr decimal
# S sum                                    sum of all 192 words in hex, runs the frame
F 0
T 1 1 5 1 1 5 50 0f0 1
P 17 0f0
P 21 0f0
P 81 0f0
P 82 222
P 191 f00
S 19470
# Near over far, equal depth keeps the first, far after near is dropped
F 0
T 0 0 6 0 0 6 90 f80 0
T 2 2 6 2 2 6 40 08f 0
T 2 2 6 2 2 6 40 fff 0
T 9 0 13 0 9 4 20 f0f 0
T 9 0 13 0 9 4 60 0ff 1
P 0 f80
P 6 f80
P 17 f80
P 34 08f
P 38 08f
P 9 f0f
P 58 f0f
P 191 00f
S 367c7
# Grey from depth
F 1
T 3 3 7 3 3 7 a7 0f0 0
T 4 4 8 4 4 8 5c 0f0 1
P 51 aaa
P 55 aaa
P 115 aaa
P 68 555
P 72 555
P 191 f00
S 22323

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for 5 cycles, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
    end

endmodule

/* vlog.f */
design/render_pkg.sv
design/pipe_stage.sv
design/background_drawer.sv
design/rasterizer.sv
design/depth_buffer.sv
design/drawing_manager.sv
testbench/tb_clock.sv
testbench/drawing_manager_tb.sv
